// File: tests/program.hex
// OPC5 test program, one 16-bit word per hex field.
// Each row holds instructions followed by their second word, if any. @ sets the address.
@000
E001 1234  EC01 0100        // r1 = 1234.
E002 8000  EC02 0101
E003 5555  C003             // Load from r0 clears r3.
EC03 0102  EC00 0103
@00F
E004 1111  C414  EC04 0200  // r4 = r4 + r1.
C422  EC02 0201             // 8000 + 8000 carries out.
6404 0001  EC04 0202        // Runs only on carry.
E801 00FF  EC01 0203
@01F
6005 AAAA  4015  EC05 0300  // Carry clear, both skipped.
A005 0F0F  EC05 0301
C006  A005 7777  EC05 0302  // Zero set, so no load.
E007 FFFF  E407 0002        // Sets carry.
6005 1357  EC05 0303  EC07 0304
@037
E008 0F00                   // Base of data table.
F089 0002  EC09 0400
F489 0003  EC09 0401
D08A  EC0A 0402
@044
E00F 0048  EC01 05FF        // Jump over a store.
E00B 0003                   // Loop count.
EC0B 0500  E40B FFFF  A00F 004A
EC0B 0501
E40F 0002  EC01 05FE        // Relative jump.
@056
E00C 0600  ECC1 0005  ECC4 000A
CCC9  ECCA F000             // Upper bits wrap in memory.
E40C 0020  ECCC 0001
E00F 0063                   // Jump to itself.
@F00
CAFE 0000 BEEF 0011         // Data table.

// File: filelist.f
+incdir+tests
source/opc5_pkg.sv
source/opc5_memory.sv
source/opc5_control.sv
source/opc5_datapath.sv
source/opc5_system.sv
tests/opc5_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = opc5_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard source/*.sv tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/opc5_ref_model.svh
`ifndef OPC5_REF_MODEL_SVH
`define OPC5_REF_MODEL_SVH

typedef opc5_bus_t store_list_t[$];

localparam int REF_STEP_LIMIT = 10000;                      // Guards against a runaway program.

logic [WORD_WIDTH-1:0] ref_image [MEM_WORDS];

// Instruction-set model of the program image. Returns every store in order.
function automatic store_list_t run_reference();
   logic [WORD_WIDTH-1:0] regs [NUM_REGS];
   logic [WORD_WIDTH-1:0] pc;
   logic [WORD_WIDTH-1:0] start;
   logic [WORD_WIDTH-1:0] opnd;
   logic [WORD_WIDTH-1:0] dst_val;
   logic [WORD_WIDTH-1:0] result;
   logic [WORD_WIDTH:0]   sum;
   logic                  carry;
   logic                  zero;
   logic                  halted;
   opc5_instr_t           ins;
   opc5_bus_t             st;
   store_list_t           stores;
   int                    i;
   int                    step;

   $readmemh(MEM_INIT_FILE, ref_image);
   for (i = 0; i < NUM_REGS; i++)
      regs[i] = '0;
   pc     = '0;
   carry  = 1'b0;
   zero   = 1'b0;
   halted = 1'b0;

   for (step = 0; step < REF_STEP_LIMIT && !halted; step++)
   begin
      start = pc;
      ins   = opc5_instr_t'(ref_image[pc[MEM_ADDR_BITS-1:0]]);
      pc    = pc + WORD_WIDTH'(1);
      opnd  = '0;
      if (ins.two_word)
      begin
         opnd = ref_image[pc[MEM_ADDR_BITS-1:0]];            // Immediate or offset.
         pc   = pc + WORD_WIDTH'(1);
      end
      // Each flag must hold unless its predicate bit waives it.
      if ((ins.pred_c || carry) && (ins.pred_nz || !zero))
      begin
         opnd = opnd + ((ins.src == REG_PC) ? pc : regs[ins.src]);
         if (ins.mem_read)
            opnd = ref_image[opnd[MEM_ADDR_BITS-1:0]];
         dst_val = (ins.dst == REG_PC) ? pc : regs[ins.dst];
         if (ins.op == STO)
         begin
            st.address    = opnd;
            st.write_data = dst_val;
            st.write      = 1'b1;
            stores.push_back(st);
            ref_image[opnd[MEM_ADDR_BITS-1:0]] = dst_val;
         end
         else
         begin
            sum = {1'b0, dst_val} + {1'b0, opnd};
            case (ins.op)
               ADD:
               begin
                  result = sum[WORD_WIDTH-1:0];
                  carry  = sum[WORD_WIDTH];
               end
               NAND:    result = ~(dst_val & opnd);
               default: result = opnd;                        // Load.
            endcase
            zero = (result == '0);
            if (ins.dst == REG_PC)
            begin
               halted = (result == start);                    // Jump to itself ends the run.
               pc     = result;
            end
            else if (ins.dst != REG_ZERO)
               regs[ins.dst] = result;
         end
      end
   end
   return stores;
endfunction

`endif

// File: tests/opc5_tb.sv
`timescale 1ns/100ps
`default_nettype none

module opc5_tb
   import opc5_pkg::*;
();

   `include "opc5_ref_model.svh"

   localparam int TIMEOUT_CYCLES = 200;

   logic        clk;
   logic        reset_b;
   opc5_bus_t   store_bus;
   store_list_t expected;
   int          total_pass;
   int          total_fail;

   opc5_system u_dut (
      .clk       (clk),
      .reset_b   (reset_b),
      .store_bus (store_bus)
   );

   always #5 clk = ~clk;                                     // 10 ns period.

   // Tests are told apart by the page of the store address.
   function automatic int test_of(input opc5_bus_t s);
      return int'(s.address[11:8]) - 1;
   endfunction

   function automatic string test_name(input int idx);
      case (idx)
         0:       return "imm_load";
         1:       return "add_nand";
         2:       return "predicate";
         3:       return "mem_read";
         4:       return "pc_dest";
         5:       return "store_addr";
         default: return "unknown";
      endcase
   endfunction

   // The strobe is steady mid-cycle. The write itself lands on the next rising edge.
   task automatic wait_store(output opc5_bus_t seen, output logic found);
      int cycles;
      found  = 1'b0;
      cycles = 0;
      seen   = '0;
      while (!found && cycles < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         cycles++;
         if (store_bus.write)
         begin
            seen  = store_bus;
            found = 1'b1;
         end
      end
   endtask

   task automatic check_store(input string name, input opc5_bus_t exp, input opc5_bus_t act,
                              output logic ok);
      ok = act.write && (act.address == exp.address) && (act.write_data == exp.write_data);
      if (!ok)
         $display("Mismatch in test %s: expected addr %h data %h, actual addr %h data %h",
                  name, exp.address, exp.write_data, act.address, act.write_data);
   endtask

   task automatic report_test(input int idx, input int n_ok, input int n_bad);
      if (n_bad == 0)
         $display("Test %s: %0d stores matched", test_name(idx), n_ok);
      else
         $display("Test %s: %0d of %0d stores wrong", test_name(idx), n_bad, n_ok + n_bad);
      total_pass += n_ok;
      total_fail += n_bad;
   endtask

   initial
   begin
      opc5_bus_t seen;
      logic      found;
      logic      ok;
      logic      timed_out;
      int        idx;
      int        cur_test;
      int        n_ok;
      int        n_bad;

      clk        = 1'b0;
      reset_b    = 1'b0;
      total_pass = 0;
      total_fail = 0;
      timed_out  = 1'b0;
      cur_test   = 0;
      n_ok       = 0;
      n_bad      = 0;
      expected   = run_reference();
      repeat (10) @(negedge clk);
      reset_b = 1'b1;

      if (expected.size() == 0)
      begin
         $display("The reference model found no stores in the program");
         total_fail++;
      end
      else
         cur_test = test_of(expected[0]);

      for (idx = 0; idx < expected.size() && !timed_out; idx++)
      begin
         if (test_of(expected[idx]) != cur_test)
         begin
            report_test(cur_test, n_ok, n_bad);
            cur_test = test_of(expected[idx]);
            n_ok     = 0;
            n_bad    = 0;
         end
         wait_store(seen, found);
         if (!found)
         begin
            $display("Test %s: no store arrived within %0d cycles",
                     test_name(cur_test), TIMEOUT_CYCLES);
            timed_out = 1'b1;
            n_bad++;
         end
         else
         begin
            check_store(test_name(cur_test), expected[idx], seen, ok);
            if (ok)
               n_ok++;
            else
               n_bad++;
         end
      end
      if (expected.size() != 0)
         report_test(cur_test, n_ok, n_bad);

      // The program parks in a self jump, so the bus stays quiet.
      if (!timed_out)
      begin
         wait_store(seen, found);
         if (found)
         begin
            $display("An extra store to address %h with data %h came after the last one",
                     seen.address, seen.write_data);
            total_fail++;
         end
      end

      $display("Stores checked: %0d passed, %0d failed", total_pass, total_fail);
      if (total_fail == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/opc5_system.sv
`timescale 1ns/100ps
`default_nettype none

module opc5_system
   import opc5_pkg::*;
(
   input  wire logic clk,
   input  wire logic reset_b,
   output opc5_bus_t store_bus
);

   opc5_state_e           state;
   opc5_instr_t           instr;
   logic [WORD_WIDTH-1:0] pc;
   logic [WORD_WIDTH-1:0] read_data;                         // Shared by fetch and operand.
   logic [WORD_WIDTH-1:0] result;
   opc5_flags_t           flags;
   opc5_bus_t             bus;

   opc5_control u_control (
      .clk       (clk),
      .reset_b   (reset_b),
      .read_data (read_data),
      .flags     (flags),
      .result    (result),
      .state     (state),
      .instr     (instr),
      .pc        (pc)
   );

   opc5_datapath u_datapath (
      .clk       (clk),
      .reset_b   (reset_b),
      .state     (state),
      .instr     (instr),
      .pc        (pc),
      .read_data (read_data),
      .flags     (flags),
      .result    (result),
      .bus       (bus)
   );

   opc5_memory u_memory (
      .clk       (clk),
      .bus       (bus),
      .read_data (read_data)
   );

   // Stores are visible outside on the write strobe.
   assign store_bus = bus;

endmodule

`default_nettype wire

// File: source/opc5_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module opc5_datapath
   import opc5_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset_b,
   input  wire opc5_state_e           state,
   input  wire opc5_instr_t           instr,
   input  wire logic [WORD_WIDTH-1:0] pc,
   input  wire logic [WORD_WIDTH-1:0] read_data,
   output opc5_flags_t                flags,
   output logic [WORD_WIDTH-1:0]      result,
   output opc5_bus_t                  bus
);

   logic [WORD_WIDTH-1:0]    regs [NUM_REGS];
   logic [WORD_WIDTH-1:0]    operand;                        // Immediate plus source.
   logic [REG_ADDR_BITS-1:0] reg_addr;
   logic [WORD_WIDTH-1:0]    reg_out;
   logic                     carry_out;
   logic                     use_dst;

   // Destination is read in EXEC and WRMEM, the source otherwise.
   assign use_dst  = (state == EXEC) || (state == WRMEM);
   assign reg_addr = use_dst ? instr.dst : instr.src;

   always_comb
   begin
      if (reg_addr == REG_PC)
         reg_out = pc;
      else if (reg_addr == REG_ZERO)
         reg_out = '0;
      else
         reg_out = regs[reg_addr];
   end

   always_ff @(posedge clk)
   begin
      case (state)
         FETCH0:        operand <= '0;                       // One-word form has no immediate.
         FETCH1, RDMEM: operand <= read_data;
         EA_ED:         operand <= operand + reg_out;
         default:       operand <= operand;
      endcase
   end

   // ALU, destination register against the operand
   always_comb
   begin
      carry_out = flags.carry;
      case (instr.op)
         LD:      result = operand;
         ADD:     {carry_out, result} = {1'b0, reg_out} + {1'b0, operand};
         NAND:    result = ~(reg_out & operand);
         default: result = operand;                          // Store writes nothing back.
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (state == EXEC)
         regs[instr.dst] <= result;                          // r0 and r15 entries never read.
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         flags <= '0;
      else if (state == EXEC)
      begin
         flags.carry <= carry_out;
         flags.zero  <= ~|result;
      end
   end

   always_comb
   begin
      if (state == RDMEM || state == WRMEM)
         bus.address = operand;                              // Effective address.
      else
         bus.address = pc;
      bus.write_data = reg_out;
      bus.write      = (state == WRMEM);
   end

endmodule

`default_nettype wire

// File: source/opc5_control.sv
`timescale 1ns/100ps
`default_nettype none

module opc5_control
   import opc5_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  reset_b,
   input  wire logic [WORD_WIDTH-1:0] read_data,
   input  wire opc5_flags_t           flags,
   input  wire logic [WORD_WIDTH-1:0] result,
   output opc5_state_e                state,
   output opc5_instr_t                instr,
   output logic [WORD_WIDTH-1:0]      pc
);

   opc5_state_e state_next;
   opc5_instr_t fetched;                                     // Word on the bus in FETCH0.

   // Carry and zero predicate test against the current flags
   function automatic logic pred_ok(input opc5_instr_t ins, input opc5_flags_t f);
      logic c_ok;
      logic z_ok;
      c_ok = ins.pred_c | f.carry;
      z_ok = ins.pred_nz | ~f.zero;
      return c_ok & z_ok;
   endfunction

   assign fetched = opc5_instr_t'(read_data);

   // Flags only change in EXEC, so the test can run as soon as the word is seen.
   always_comb
   begin
      state_next = FETCH0;
      case (state)
         FETCH0:
         begin
            if (fetched.two_word)
               state_next = FETCH1;                          // Second word comes first.
            else if (pred_ok(fetched, flags))
               state_next = EA_ED;
            else
               state_next = FETCH0;                          // Skipped, one cycle.
         end
         FETCH1:
         begin
            if (pred_ok(instr, flags))
               state_next = EA_ED;
            else
               state_next = FETCH0;                          // Skipped, two cycles.
         end
         EA_ED:
         begin
            if (instr.mem_read)
               state_next = RDMEM;
            else if (instr.op == STO)
               state_next = WRMEM;
            else
               state_next = EXEC;
         end
         RDMEM:
         begin
            if (instr.op == STO)
               state_next = WRMEM;
            else
               state_next = EXEC;
         end
         default:
            state_next = FETCH0;                             // EXEC and WRMEM end here.
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= FETCH0;
      else
         state <= state_next;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         instr <= '0;
      else if (state == FETCH0)
         instr <= fetched;
   end

   // PC steps past each fetched word; a write to r15 is a jump.
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc <= '0;
      else if (state == FETCH0 || state == FETCH1)
         pc <= pc + WORD_WIDTH'(1);
      else if (state == EXEC && instr.dst == REG_PC)
         pc <= result;
   end

endmodule

`default_nettype wire

// File: source/opc5_memory.sv
`timescale 1ns/100ps
`default_nettype none

module opc5_memory
   import opc5_pkg::*;
(
   input  wire logic                  clk,
   input  wire opc5_bus_t             bus,
   output logic [WORD_WIDTH-1:0]      read_data
);

   logic [WORD_WIDTH-1:0]    mem [MEM_WORDS];
   logic [MEM_ADDR_BITS-1:0] word_addr;

   // Addresses wrap at the memory size.
   assign word_addr = bus.address[MEM_ADDR_BITS-1:0];

   initial
   begin
      $readmemh(MEM_INIT_FILE, mem);                         // Program and data image.
   end

   // Same-cycle read for fetch and operand loads
   assign read_data = mem[word_addr];

   always_ff @(posedge clk)
   begin
      if (bus.write)
         mem[word_addr] <= bus.write_data;                   // Lands at end of WRMEM.
   end

endmodule

`default_nettype wire

// File: source/opc5_pkg.sv
`default_nettype none

package opc5_pkg;

   localparam int WORD_WIDTH    = 16;                         // Data and address word.
   localparam int MEM_ADDR_BITS = 12;                         // Upper address bits ignored.
   localparam int MEM_WORDS     = 2 ** MEM_ADDR_BITS;
   localparam int NUM_REGS      = 16;
   localparam int REG_ADDR_BITS = 4;

   localparam logic [REG_ADDR_BITS-1:0] REG_PC   = 4'd15;    // Reads and writes the PC.
   localparam logic [REG_ADDR_BITS-1:0] REG_ZERO = 4'd0;     // Always reads as zero.

   // Program image loaded into memory at time zero
   localparam string MEM_INIT_FILE = "tests/program.hex";

   // Sequencer states, one clock each
   typedef enum logic [2:0] {
      FETCH0 = 3'd0,                                         // First instruction word.
      FETCH1 = 3'd1,                                         // Second word, immediate.
      EA_ED  = 3'd2,                                         // Effective address.
      RDMEM  = 3'd3,                                         // Operand from memory.
      EXEC   = 3'd4,                                         // ALU result to register.
      WRMEM  = 3'd5                                          // Register to memory.
   } opc5_state_e;

   typedef enum logic [1:0] {
      LD   = 2'b00,
      ADD  = 2'b01,
      NAND = 2'b10,
      STO  = 2'b11
   } opc5_op_e;

   // Instruction word, top bit first
   typedef struct packed {
      logic                     pred_c;                      // Set means ignore carry.
      logic                     pred_nz;                     // Set means ignore zero.
      logic                     two_word;
      logic                     mem_read;
      opc5_op_e                 op;
      logic [1:0]               reserved;
      logic [REG_ADDR_BITS-1:0] src;
      logic [REG_ADDR_BITS-1:0] dst;
   } opc5_instr_t;

   typedef struct packed {
      logic carry;
      logic zero;
   } opc5_flags_t;

   // Memory bus, store side also seen outside the system
   typedef struct packed {
      logic [WORD_WIDTH-1:0] address;
      logic [WORD_WIDTH-1:0] write_data;
      logic                  write;                          // Strobe, high in WRMEM only.
   } opc5_bus_t;

endpackage

`default_nettype wire
